// File: Makefile
VERILATOR ?= verilator
TOP       ?= dagTb
FILELIST  ?= list.f
BUILDDIR  ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASSMSG   ?= Done: no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILDDIR) -f $(FILELIST)
	./$(BUILDDIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASSMSG)" $(LOG)

clean:
	rm -rf $(BUILDDIR) $(LOG)

// File: list.f
+incdir+verif
verilog/dagPkg.sv
verilog/dagBus.sv
verilog/dagRegs.sv
verilog/moduloUpdate.sv
verilog/chanSequencer.sv
verilog/dagTop.sv
verif/dagTb.sv

// File: verif/dagTbTable.svh
`ifndef DAG_TB_TABLE_SVH
`define DAG_TB_TABLE_SVH

// One directed update per row. The expected address is always the old I.
typedef struct packed
{
  chanE                 chan;
  logic [addrWidth-1:0] idx;
  logic [addrWidth-1:0] mod;
  logic [addrWidth-1:0] len;
  logic [addrWidth-1:0] expAddr;
  logic [addrWidth-1:0] expNewI;
  logic                 expWrap;
} rowT;

localparam int numRows = 12;

localparam rowT dirRows [numRows] = '{
  //  chan    I          M          L          addr       new I      wrap
  '{chanT0, 14'h0100, 14'h0003, 14'h0000, 14'h0100, 14'h0103, 1'b0},  // Linear forward.
  '{chanT1, 14'h0200, 14'h3FFF, 14'h0000, 14'h0200, 14'h01FF, 1'b0},  // Linear backward.
  '{chanR0, 14'h0044, 14'h0004, 14'h0010, 14'h0044, 14'h0048, 1'b0},  // L of 16, inside.
  '{chanR1, 14'h004E, 14'h0003, 14'h0010, 14'h004E, 14'h0041, 1'b1},  // Past the top.
  '{chanT0, 14'h0041, 14'h3FFD, 14'h0010, 14'h0041, 14'h004E, 1'b1},  // Below the base.
  '{chanT1, 14'h0085, 14'h0002, 14'h000A, 14'h0085, 14'h0087, 1'b0},  // L of 10, inside.
  '{chanR0, 14'h0088, 14'h0003, 14'h000A, 14'h0088, 14'h0081, 1'b1},
  '{chanR1, 14'h0081, 14'h3FFB, 14'h000A, 14'h0081, 14'h0086, 1'b1},
  '{chanT0, 14'h0309, 14'h0001, 14'h000A, 14'h0309, 14'h0300, 1'b1},  // Lands exactly on L.
  '{chanT1, 14'h0125, 14'h0020, 14'h0064, 14'h0125, 14'h0145, 1'b0},  // L of 100.
  '{chanR0, 14'h0160, 14'h0008, 14'h0064, 14'h0160, 14'h0104, 1'b1},
  '{chanR1, 14'h0102, 14'h3FF8, 14'h0064, 14'h0102, 14'h015E, 1'b1}
};

`endif

// File: verif/dagTb.sv
`default_nettype none

module dagTb
  import dagPkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  logic                 DSPCLK;
  logic                 reset;
  logic                 psel;
  logic                 penable;
  logic                 pwrite;
  logic [5:0]           paddr;
  logic [addrWidth-1:0] pwdata;
  logic [addrWidth-1:0] prdata;
  logic                 pready;
  logic                 pslverr;
  logic [numChan-1:0]   chanReq;
  logic [numChan-1:0]   chanAck;
  logic [numChan-1:0]   chanWrap;
  logic [addrWidth-1:0] chanAddr;

  int     errCount;
  int     testErr;                // Errors in the test now running.
  int     testCount;
  integer seed;

  `include "dagTbTable.svh"

  localparam int     numSweep    = 100;
  localparam longint watchdogNs  = longint'(numRows + numSweep) * 20 * 40;

  dagTop #(.addrWidth(addrWidth)) DUT
  (
    .DSPCLK   (DSPCLK),
    .reset    (reset),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .paddr    (paddr),
    .pwdata   (pwdata),
    .prdata   (prdata),
    .pready   (pready),
    .pslverr  (pslverr),
    .chanReq  (chanReq),
    .chanAck  (chanAck),
    .chanWrap (chanWrap),
    .chanAddr (chanAddr)
  );

  initial
  begin
    DSPCLK = 1'b0;
    forever #20 DSPCLK = ~DSPCLK;
  end

  initial
  begin
    #(watchdogNs);
    $display("Watchdog expired before the tests finished.");
    $display("Done: errors found");
    $finish;
  end

  task automatic compareValue(input string name, input logic [addrWidth-1:0] expected,
                              input logic [addrWidth-1:0] actual);
    if (actual !== expected)
    begin
      $display("Fail %s: expected %h, got %h", name, expected, actual);
      testErr++;
    end
  endtask

  task automatic compareFlag(input string name, input logic expected, input logic actual);
    if (actual !== expected)
    begin
      $display("Fail %s: expected %h, got %h", name, expected, actual);
      testErr++;
    end
  endtask

  task automatic finishTest(input string name);
    if (testErr == 0)
      $display("Test %s: ok", name);
    else
      $display("Test %s: %0d errors", name, testErr);
    errCount += testErr;
    testErr = 0;
    testCount++;
  endtask

  task automatic writeReg(input logic [5:0] addr, input logic [addrWidth-1:0] data);
    @(posedge DSPCLK);
    psel    <= 1'b1;              // Setup phase.
    pwrite  <= 1'b1;
    penable <= 1'b0;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge DSPCLK);
    penable <= 1'b1;              // Access phase taken at the next edge.
    @(posedge DSPCLK);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic readReg(input logic [5:0] addr, output logic [addrWidth-1:0] data,
                         output logic err);
    @(posedge DSPCLK);
    psel    <= 1'b1;
    pwrite  <= 1'b0;
    penable <= 1'b0;
    paddr   <= addr;
    @(posedge DSPCLK);
    penable <= 1'b1;
    @(negedge DSPCLK);
    data = prdata;                // Sampled mid access with zero wait states.
    err  = pslverr;
    compareFlag("pready", 1'b1, pready);
    @(posedge DSPCLK);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic loadSet(input chanE ch, input logic [addrWidth-1:0] idx,
                         input logic [addrWidth-1:0] mod, input logic [addrWidth-1:0] len);
    writeReg({ch, regI}, idx);
    writeReg({ch, regM}, mod);
    writeReg({ch, regL}, len);
  endtask

  // Holds the request until the acknowledge shows and then drops it.
  task automatic requestChannel(input chanE ch, output logic [addrWidth-1:0] addr,
                                output logic wrapped);
    int   waitCycles;
    logic seen;
    waitCycles = 0;
    seen       = 1'b0;
    addr       = '0;
    wrapped    = 1'b0;
    @(posedge DSPCLK);
    chanReq[ch] <= 1'b1;
    while (!seen && waitCycles < 8)
    begin
      @(negedge DSPCLK);
      waitCycles++;
      if (chanAck[ch])
      begin
        seen    = 1'b1;
        addr    = chanAddr;
        wrapped = chanWrap[ch];
      end
    end
    @(posedge DSPCLK);
    chanReq[ch] <= 1'b0;
    if (!seen)
    begin
      $display("Channel %0d request was never acknowledged.", ch);
      testErr++;
    end
  endtask

  // Circular update rule worked out on plain integers.
  task automatic modelUpdate(input logic [addrWidth-1:0] idx, input logic [addrWidth-1:0] mod,
                             input logic [addrWidth-1:0] len,
                             output logic [addrWidth-1:0] nextIdx, output logic wrapped);
    int k;
    int lenInt;
    int base;
    int offset;
    int sum;
    lenInt  = int'(len);
    wrapped = 1'b0;
    if (lenInt == 0)
      nextIdx = idx + mod;
    else
    begin
      k = 0;
      while ((1 << k) < lenInt)
        k++;
      offset = int'(idx) % (1 << k);
      base   = int'(idx) - offset;
      sum    = mod[addrWidth-1] ? offset + int'(mod) - (1 << addrWidth) : offset + int'(mod);
      if (sum >= lenInt)
      begin
        sum     = sum - lenInt;
        wrapped = 1'b1;
      end
      else if (sum < 0)
      begin
        sum     = sum + lenInt;
        wrapped = 1'b1;
      end
      sum     = base + sum;
      nextIdx = sum[addrWidth-1:0];    // Address space wraps at its width.
    end
  endtask

  task automatic readbackTest();
    regE                  regList [3];
    logic [addrWidth-1:0] data;
    logic                 err;
    regList = '{regI, regM, regL};
    for (int s = 0; s < numChan; s++)
      for (int r = 0; r < 3; r++)
        writeReg({s[1:0], regList[r]}, {s[1:0], regList[r], 8'h3C});
    for (int s = 0; s < numChan; s++)
    begin
      for (int r = 0; r < 3; r++)
      begin
        readReg({s[1:0], regList[r]}, data, err);
        compareValue("prdata", {s[1:0], regList[r], 8'h3C}, data);
        compareFlag("pslverr", 1'b0, err);
      end
    end
    readReg({2'd1, 4'hC}, data, err);   // Holes in the map.
    compareFlag("pslverr", 1'b1, err);
    readReg({2'd2, 4'h2}, data, err);
    compareFlag("pslverr", 1'b1, err);
  endtask

  task automatic runRow(input int r);
    logic [addrWidth-1:0] addr;
    logic [addrWidth-1:0] data;
    logic                 wrapped;
    logic                 err;
    loadSet(dirRows[r].chan, dirRows[r].idx, dirRows[r].mod, dirRows[r].len);
    requestChannel(dirRows[r].chan, addr, wrapped);
    compareValue("chanAddr", dirRows[r].expAddr, addr);
    compareFlag("chanWrap", dirRows[r].expWrap, wrapped);
    readReg({dirRows[r].chan, regI}, data, err);
    compareValue("I", dirRows[r].expNewI, data);
  endtask

  task automatic walkTest();
    logic [addrWidth-1:0] cur;
    logic [addrWidth-1:0] nxt;
    logic [addrWidth-1:0] addr;
    logic [addrWidth-1:0] data;
    logic                 expWrap;
    logic                 wrapped;
    logic                 err;
    cur = 14'h0204;
    loadSet(chanT1, cur, 14'h0003, 14'h0006);
    for (int n = 0; n < 8; n++)
    begin
      modelUpdate(cur, 14'h0003, 14'h0006, nxt, expWrap);
      requestChannel(chanT1, addr, wrapped);
      compareValue("chanAddr", cur, addr);
      compareFlag("chanWrap", expWrap, wrapped);
      cur = nxt;
    end
    readReg({chanT1, regI}, data, err);
    compareValue("I", cur, data);
  endtask

  task automatic priorityTest();
    logic [numChan-1:0]   ackNow;
    logic [numChan-1:0]   expAck;
    logic [addrWidth-1:0] data;
    logic                 err;
    int                   got;
    int                   waitCycles;
    for (int c = 0; c < numChan; c++)
      loadSet(chanE'(c), {c[1:0], 12'h123}, 14'h0002, 14'h0000);
    got        = 0;
    waitCycles = 0;
    @(posedge DSPCLK);
    chanReq <= '1;                // All four at once.
    while (got < numChan && waitCycles < 16)
    begin
      @(negedge DSPCLK);
      waitCycles++;
      ackNow = chanAck;
      if (ackNow != '0)
      begin
        expAck = {{(numChan-1){1'b0}}, 1'b1} << got;
        if (ackNow != expAck)
        begin
          $display("Fail chanAck: expected %h, got %h", expAck, ackNow);
          testErr++;
        end
        compareValue("chanAddr", {got[1:0], 12'h123}, chanAddr);
        got++;
      end
      @(posedge DSPCLK);
      chanReq <= chanReq & ~ackNow;
    end
    chanReq <= '0;
    if (got < numChan)
    begin
      $display("Only %0d of %0d channels were acknowledged.", got, numChan);
      testErr++;
    end
    for (int c = 0; c < numChan; c++)
    begin
      readReg({c[1:0], regI}, data, err);
      compareValue("I", {c[1:0], 12'h125}, data);
    end
  endtask

  task automatic sweepTest();
    int                   rnd;
    chanE                 ch;
    logic [addrWidth-1:0] idx;
    logic [addrWidth-1:0] mod;
    logic [addrWidth-1:0] len;
    logic [addrWidth-1:0] expI;
    logic [addrWidth-1:0] addr;
    logic [addrWidth-1:0] data;
    logic                 expWrap;
    logic                 wrapped;
    logic                 err;
    for (int n = 0; n < numSweep; n++)
    begin
      rnd = $random(seed);
      ch  = chanE'(rnd[1:0]);
      rnd = $random(seed);
      idx = rnd[addrWidth-1:0];
      rnd = $random(seed);
      len = {7'd0, rnd[6:0]};     // Short buffers so wraps are common.
      rnd = $random(seed) % 48;
      mod = rnd[addrWidth-1:0];
      loadSet(ch, idx, mod, len);
      modelUpdate(idx, mod, len, expI, expWrap);
      requestChannel(ch, addr, wrapped);
      compareValue("chanAddr", idx, addr);
      compareFlag("chanWrap", expWrap, wrapped);
      readReg({ch, regI}, data, err);
      compareValue("I", expI, data);
    end
  endtask

  initial
  begin
    errCount  = 0;
    testErr   = 0;
    testCount = 0;
    seed      = 47667;
    reset   <= 1'b1;
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= '0;
    pwdata  <= '0;
    chanReq <= '0;
    repeat (16) @(posedge DSPCLK);
    reset <= 1'b0;

    readbackTest();
    finishTest("APB readback");
    for (int r = 0; r < numRows; r++)
    begin
      runRow(r);
      finishTest($sformatf("table row %0d", r));
    end
    walkTest();
    finishTest("buffer walk");
    priorityTest();
    finishTest("priority");
    sweepTest();
    finishTest("random sweep");

    $display("Tests run: %0d, errors: %0d", testCount, errCount);
    if (errCount == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/chanSequencer.sv
`default_nettype none

module chanSequencer
  import dagPkg::*;
#(
  parameter int addrWidth = dagPkg::addrWidth
)
(
  input  logic                 DSPCLK,
  input  logic                 reset,
  input  logic [numChan-1:0]   chanReq,
  output logic [numChan-1:0]   chanAck,
  output logic [numChan-1:0]   chanWrap,
  output logic [addrWidth-1:0] chanAddr,
  input  logic                 wrap,
  dagBus.seq                   bus
);

  seqStateE           state;
  chanE               winner;
  logic [numChan-1:0] issueOh;    // Channel retiring at the next edge.
  logic [numChan-1:0] pending;    // Requests eligible for a grant.

  assign issueOh = (state == seqIssue) ? ({{(numChan-1){1'b0}}, 1'b1} << bus.setSel) : '0;

  // Hide the channel being acknowledged and the one whose ack is showing.
  assign pending = chanReq & ~(issueOh | chanAck);

  // Fixed priority, lowest index wins.
  always_comb
  begin
    winner = chanT0;
    for (int c = numChan - 1; c >= 0; c--)
    begin
      if (pending[c])
        winner = chanE'(c);
    end
  end

  assign bus.updateWe = (state == seqIssue);

  always_ff @(posedge DSPCLK)
  begin
    if (reset)
    begin
      state      <= seqIdle;
      bus.setSel <= chanT0;
      chanAck    <= '0;
      chanWrap   <= '0;
      chanAddr   <= '0;
    end
    else
    begin
      chanAck  <= issueOh;                     // One-cycle pulse.
      chanWrap <= wrap ? issueOh : '0;
      if (state == seqIssue)
        chanAddr <= bus.curI;                  // Old I, before write-back.
      if (|pending)
      begin
        state      <= seqIssue;
        bus.setSel <= winner;
      end
      else
        state <= seqIdle;
    end
  end

  ackOneHot: assert property (@(posedge DSPCLK) disable iff (reset) $onehot0(chanAck))
    else $error("chanSequencer: more than one chanAck bit set.");

  wrapWithAck: assert property (@(posedge DSPCLK) disable iff (reset)
    (chanWrap & ~chanAck) == '0)
    else $error("chanSequencer: chanWrap without chanAck.");

endmodule

`default_nettype wire

// File: verilog/dagBus.sv
`default_nettype none

interface dagBus
  import dagPkg::*;
#(
  parameter int addrWidth = dagPkg::addrWidth
)
();

  chanE                 setSel;     // Register set under update.
  logic [addrWidth-1:0] curI;       // Current index of that set.
  logic [addrWidth-1:0] curM;       // Its modifier.
  logic [addrWidth-1:0] curL;       // Its length.
  logic [addrWidth-1:0] newI;       // Updated index.
  logic                 updateWe;   // Write newI back at the next edge.

  modport regs (input setSel, updateWe, newI, output curI, curM, curL);

  modport seq (output setSel, updateWe, input curI);

  modport alu (input curI, curM, curL, output newI);

endinterface

`default_nettype wire

// File: verilog/dagPkg.sv
`default_nettype none

package dagPkg;

  // Width of I, M, L and of every returned address.
  parameter int addrWidth = 14;

  // Autobuffer channels, one register set each.
  parameter int numChan = 4;

  // Channel order is also the grant priority, highest first.
  typedef enum logic [1:0]
  {
    chanT0 = 2'd0,                // Transmit 0.
    chanT1 = 2'd1,                // Transmit 1.
    chanR0 = 2'd2,                // Receive 0.
    chanR1 = 2'd3                 // Receive 1.
  } chanE;

  // Offsets inside one 16-byte register set on APB.
  typedef enum logic [3:0]
  {
    regI = 4'd0,                  // Index.
    regM = 4'd4,                  // Modifier.
    regL = 4'd8                   // Length.
  } regE;

  // Sequencer states.
  typedef enum logic
  {
    seqIdle  = 1'b0,              // No update pending.
    seqIssue = 1'b1               // Granted set is being updated.
  } seqStateE;

endpackage

`default_nettype wire

// File: verilog/dagRegs.sv
`default_nettype none

module dagRegs
  import dagPkg::*;
#(
  parameter int addrWidth = dagPkg::addrWidth
)
(
  input  logic                 DSPCLK,
  input  logic                 reset,
  input  logic                 psel,
  input  logic                 penable,
  input  logic                 pwrite,
  input  logic [5:0]           paddr,
  input  logic [addrWidth-1:0] pwdata,
  output logic [addrWidth-1:0] prdata,
  output logic                 pready,
  output logic                 pslverr,
  dagBus.regs                  bus
);

  logic [addrWidth-1:0] iReg [numChan];
  logic [addrWidth-1:0] mReg [numChan];
  logic [addrWidth-1:0] lReg [numChan];

  logic [1:0] apbSet;             // Set number from the address.
  logic       offValid;           // Offset is one of regE.
  logic       apbWrite;

  assign apbSet   = paddr[5:4];
  assign apbWrite = psel && penable && pwrite && offValid;

  // Read side.
  always_comb
  begin
    offValid = 1'b1;
    prdata   = '0;
    case (paddr[3:0])
      regI:    prdata = iReg[apbSet];
      regM:    prdata = mReg[apbSet];
      regL:    prdata = lReg[apbSet];
      default: offValid = 1'b0;   // Hole in the register map.
    endcase
  end

  assign pready  = 1'b1;          // Zero wait states.
  assign pslverr = psel && !offValid;

  // Set under update, as seen by the sequencer and the update unit.
  assign bus.curI = iReg[bus.setSel];
  assign bus.curM = mReg[bus.setSel];
  assign bus.curL = lReg[bus.setSel];

  always_ff @(posedge DSPCLK)
  begin
    if (reset)
    begin
      for (int s = 0; s < numChan; s++)
      begin
        iReg[s] <= '0;
        mReg[s] <= '0;
        lReg[s] <= '0;
      end
    end
    else
    begin
      if (bus.updateWe)
        iReg[bus.setSel] <= bus.newI;     // Write-back from the sequencer.
      // APB comes last so it wins a collision on the same I.
      if (apbWrite)
      begin
        case (paddr[3:0])
          regI:    iReg[apbSet] <= pwdata;
          regM:    mReg[apbSet] <= pwdata;
          regL:    lReg[apbSet] <= pwdata;
          default: ;
        endcase
      end
    end
  end

  // Strobe must stay quiet once reset has been seen on two edges.
  regChecks: assert property (@(posedge DSPCLK)
    pready && !(reset && $past(reset) && bus.updateWe))
    else $error("dagRegs: pready low or write-back during reset.");

endmodule

`default_nettype wire

// File: verilog/dagTop.sv
`default_nettype none

module dagTop
  import dagPkg::*;
#(
  parameter int addrWidth = dagPkg::addrWidth
)
(
  input  logic                 DSPCLK,
  input  logic                 reset,
  input  logic                 psel,
  input  logic                 penable,
  input  logic                 pwrite,
  input  logic [5:0]           paddr,
  input  logic [addrWidth-1:0] pwdata,
  output logic [addrWidth-1:0] prdata,
  output logic                 pready,
  output logic                 pslverr,
  input  logic [numChan-1:0]   chanReq,
  output logic [numChan-1:0]   chanAck,
  output logic [numChan-1:0]   chanWrap,
  output logic [addrWidth-1:0] chanAddr
);

  logic wrap;                     // From the update unit to the sequencer.

  dagBus #(.addrWidth(addrWidth)) bus ();

  dagRegs #(.addrWidth(addrWidth)) uRegs
  (
    .DSPCLK  (DSPCLK),
    .reset   (reset),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .bus     (bus.regs)
  );

  moduloUpdate #(.addrWidth(addrWidth)) uUpdate
  (
    .bus  (bus.alu),
    .wrap (wrap)
  );

  chanSequencer #(.addrWidth(addrWidth)) uSeq
  (
    .DSPCLK   (DSPCLK),
    .reset    (reset),
    .chanReq  (chanReq),
    .chanAck  (chanAck),
    .chanWrap (chanWrap),
    .chanAddr (chanAddr),
    .wrap     (wrap),
    .bus      (bus.seq)
  );

endmodule

`default_nettype wire

// File: verilog/moduloUpdate.sv
`default_nettype none

module moduloUpdate
#(
  parameter int addrWidth = dagPkg::addrWidth
)
(
  dagBus.alu   bus,
  output logic wrap
);

  logic                        linear;       // L of zero, plain I plus M.
  logic [addrWidth-1:0]        lenMinus1;
  logic [addrWidth-1:0]        bufMask;      // 2^K - 1.
  logic [addrWidth-1:0]        bufBase;
  logic [addrWidth-1:0]        bufOffset;
  logic signed [addrWidth+1:0] lenExt;
  logic signed [addrWidth+1:0] modExt;       // M, sign extended.
  logic signed [addrWidth+1:0] offsetSum;
  logic signed [addrWidth+1:0] offsetFix;
  logic                        underflow;
  logic                        overflow;

  assign linear    = (bus.curL == '0);
  assign lenMinus1 = bus.curL - 1'b1;

  // Smear L-1 downward to get the mask of the next power of two.
  always_comb
  begin
    bufMask = '0;
    for (int b = 0; b < addrWidth; b++)
      bufMask[b] = |(lenMinus1 >> b);
  end

  assign bufBase   = bus.curI & ~bufMask;
  assign bufOffset = bus.curI & bufMask;

  assign lenExt    = signed'({2'b00, bus.curL});
  assign modExt    = signed'({{2{bus.curM[addrWidth-1]}}, bus.curM});
  assign offsetSum = signed'({2'b00, bufOffset}) + modExt;

  // Stepped below the buffer start.
  assign underflow = (offsetSum < 0);
  // Reached or passed the buffer end.
  assign overflow  = !underflow && (offsetSum >= lenExt);

  // One correction by L, either way.
  always_comb
  begin
    if (underflow)
      offsetFix = offsetSum + lenExt;
    else if (overflow)
      offsetFix = offsetSum - lenExt;
    else
      offsetFix = offsetSum;
  end

  assign bus.newI = linear ? bus.curI + bus.curM
                           : bufBase + offsetFix[addrWidth-1:0];

  assign wrap = !linear && (underflow || overflow);   // No wrap in linear mode.

endmodule

`default_nettype wire
